/* chip_io_defines.svh */
// IR length, IDCODE values and reset synchronizer depth for the chip IO ring
`ifndef CHIP_IO_DEFINES_SVH
`define CHIP_IO_DEFINES_SVH

// width of the TAP instruction register
`define CHIP_IR_LEN 4

// IDCODE of the main core TAP
// version 1, part 0xA5A0, manufacturer 0x6D9, LSB fixed to 1
`define CHIP_IDCODE_MAIN 32'h1A5A_0DB3

// IDCODE of the secondary core TAP
`define CHIP_IDCODE_OT 32'h2C3E_5A71

// flops in the ref_clk reset synchronizer
`define CHIP_RST_SYNC_STAGES 2

`endif

/* chip_io_pkg.sv */
// TAP controller state, TAP instruction and pad pull types
`include "chip_io_defines.svh"

package chip_io_pkg;

    // IEEE 1149.1 controller states
    typedef enum logic [3:0] {
        TAP_TEST_LOGIC_RESET,
        TAP_RUN_TEST_IDLE,
        TAP_SELECT_DR_SCAN,
        TAP_CAPTURE_DR,
        TAP_SHIFT_DR,
        TAP_EXIT1_DR,
        TAP_PAUSE_DR,
        TAP_EXIT2_DR,
        TAP_UPDATE_DR,
        TAP_SELECT_IR_SCAN,
        TAP_CAPTURE_IR,
        TAP_SHIFT_IR,
        TAP_EXIT1_IR,
        TAP_PAUSE_IR,
        TAP_EXIT2_IR,
        TAP_UPDATE_IR
    } tap_state_t;

    // unknown codes fall back to bypass
    typedef enum logic [`CHIP_IR_LEN-1:0] {
        INSTR_IDCODE = 4'b0001,
        INSTR_BYPASS = 4'b1111
    } tap_instr_t;

    typedef enum logic {
        PULL_UP,
        PULL_DOWN
    } pad_pull_t;

endpackage

/* jtag_if.sv */
// JTAG pin bundle between the pad ring and a TAP controller
`timescale 1ns/1ns

interface jtag_if;

    logic tck;
    logic tms;
    logic tdi;
    logic tdo;
    logic trst_n;

    // pad ring side, pins come in from the board
    modport pad (
        output tck,
        output tms,
        output tdi,
        output trst_n,
        input  tdo
    );

    modport tap (
        input  tck,
        input  tms,
        input  tdi,
        input  trst_n,
        output tdo
    );

endinterface

/* pad_cell.sv */
// behavioural bidirectional pad cell with output enable and weak pull
`timescale 1ns/1ns

module pad_cell
    import chip_io_pkg::*;
#(
    parameter pad_pull_t PULL = PULL_UP
) (
    input  logic oen_i,
    input  logic i_i,
    output logic o_o,
    inout  wire  pad_io
);

    // output enable is active low, released pad floats to the pull
    assign pad_io = oen_i ? 1'bz : i_i;

    // weak keeper so an undriven pad reads a defined level
    if (PULL == PULL_UP) begin : g_pull_up
        pullup (pad_io);
    end else begin : g_pull_down
        pulldown (pad_io);
    end

    // receiver always sees the pad, also when the cell drives it
    assign o_o = pad_io;

endmodule

/* pad_frame.sv */
// pad ring with UART, clock, reset, bypass and two JTAG pad groups
`timescale 1ns/1ns

module pad_frame
    import chip_io_pkg::*;
#(
    // plain wires instead of pad cells for the FPGA build
    parameter bit FPGA_EMUL = 1'b0
) (
    input  logic uart_tx_i,
    output logic uart_rx_o,
    output logic ref_clk_o,
    output logic rstn_o,
    output logic bypass_o,

    jtag_if.pad  jtag_main,
    jtag_if.pad  jtag_ot,

    inout  wire  pad_uart_rx_io,
    inout  wire  pad_uart_tx_io,
    inout  wire  pad_reset_n_io,
    inout  wire  pad_xtal_in_io,
    inout  wire  pad_bypass_io,
    inout  wire  pad_jtag_tck_io,
    inout  wire  pad_jtag_tms_io,
    inout  wire  pad_jtag_tdi_io,
    inout  wire  pad_jtag_tdo_io,
    inout  wire  pad_jtag_trst_io,
    inout  wire  pad_jtag_ot_tck_io,
    inout  wire  pad_jtag_ot_tms_io,
    inout  wire  pad_jtag_ot_tdi_io,
    inout  wire  pad_jtag_ot_tdo_io,
    inout  wire  pad_jtag_ot_trst_io
);

    if (FPGA_EMUL) begin : g_emul
        assign uart_rx_o      = pad_uart_rx_io;
        assign pad_uart_tx_io = uart_tx_i;
        assign ref_clk_o      = pad_xtal_in_io;
        assign rstn_o         = pad_reset_n_io;
        assign bypass_o       = pad_bypass_io;
        // main core jtag
        assign jtag_main.tck    = pad_jtag_tck_io;
        assign jtag_main.tms    = pad_jtag_tms_io;
        assign jtag_main.tdi    = pad_jtag_tdi_io;
        assign jtag_main.trst_n = pad_jtag_trst_io;
        assign pad_jtag_tdo_io  = jtag_main.tdo;
        // secondary core jtag
        assign jtag_ot.tck         = pad_jtag_ot_tck_io;
        assign jtag_ot.tms         = pad_jtag_ot_tms_io;
        assign jtag_ot.tdi         = pad_jtag_ot_tdi_io;
        assign jtag_ot.trst_n      = pad_jtag_ot_trst_io;
        assign pad_jtag_ot_tdo_io  = jtag_ot.tdo;
    end else begin : g_pads
        // uart, rx is an input, tx an output
        pad_cell #(.PULL(PULL_UP)) u_pad_uart_rx (
            .oen_i(1'b1), .i_i(1'b0), .o_o(uart_rx_o), .pad_io(pad_uart_rx_io));
        pad_cell #(.PULL(PULL_UP)) u_pad_uart_tx (
            .oen_i(1'b0), .i_i(uart_tx_i), .o_o(), .pad_io(pad_uart_tx_io));

        // clock, reset and bypass inputs
        pad_cell #(.PULL(PULL_UP)) u_pad_ref_clk (
            .oen_i(1'b1), .i_i(1'b0), .o_o(ref_clk_o), .pad_io(pad_xtal_in_io));
        pad_cell #(.PULL(PULL_UP)) u_pad_reset_n (
            .oen_i(1'b1), .i_i(1'b0), .o_o(rstn_o), .pad_io(pad_reset_n_io));
        pad_cell #(.PULL(PULL_UP)) u_pad_bypass (
            .oen_i(1'b1), .i_i(1'b0), .o_o(bypass_o), .pad_io(pad_bypass_io));

        // main core jtag, tdo idles low through the pull-down
        pad_cell #(.PULL(PULL_UP)) u_pad_jtag_tck (
            .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_main.tck), .pad_io(pad_jtag_tck_io));
        pad_cell #(.PULL(PULL_UP)) u_pad_jtag_tms (
            .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_main.tms), .pad_io(pad_jtag_tms_io));
        pad_cell #(.PULL(PULL_UP)) u_pad_jtag_tdi (
            .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_main.tdi), .pad_io(pad_jtag_tdi_io));
        pad_cell #(.PULL(PULL_UP)) u_pad_jtag_trst (
            .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_main.trst_n), .pad_io(pad_jtag_trst_io));
        pad_cell #(.PULL(PULL_DOWN)) u_pad_jtag_tdo (
            .oen_i(1'b0), .i_i(jtag_main.tdo), .o_o(), .pad_io(pad_jtag_tdo_io));

        // secondary core jtag
        pad_cell #(.PULL(PULL_UP)) u_pad_jtag_ot_tck (
            .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_ot.tck), .pad_io(pad_jtag_ot_tck_io));
        pad_cell #(.PULL(PULL_UP)) u_pad_jtag_ot_tms (
            .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_ot.tms), .pad_io(pad_jtag_ot_tms_io));
        pad_cell #(.PULL(PULL_UP)) u_pad_jtag_ot_tdi (
            .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_ot.tdi), .pad_io(pad_jtag_ot_tdi_io));
        pad_cell #(.PULL(PULL_UP)) u_pad_jtag_ot_trst (
            .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_ot.trst_n), .pad_io(pad_jtag_ot_trst_io));
        pad_cell #(.PULL(PULL_DOWN)) u_pad_jtag_ot_tdo (
            .oen_i(1'b0), .i_i(jtag_ot.tdo), .o_o(), .pad_io(pad_jtag_ot_tdo_io));
    end

endmodule

/* jtag_tap.sv */
// IEEE 1149.1 TAP controller with instruction, IDCODE and bypass registers
`timescale 1ns/1ns
`include "chip_io_defines.svh"

module jtag_tap
    import chip_io_pkg::*;
#(
    parameter logic [31:0] IDCODE_VALUE = `CHIP_IDCODE_MAIN
) (
    jtag_if.tap jtag
);

    // pattern loaded in Capture-IR, LSB set as the standard asks
    localparam logic [`CHIP_IR_LEN-1:0] IR_CAPTURE = {{(`CHIP_IR_LEN-1){1'b0}}, 1'b1};

    tap_state_t                state_q;
    tap_state_t                state_d;
    logic [`CHIP_IR_LEN-1:0]   ir_q;
    logic [`CHIP_IR_LEN-1:0]   ir_shift_q;
    logic [31:0]               idcode_q;
    logic                      bypass_q;
    logic                      idcode_sel;
    logic                      tdo_q;

    always_comb begin
        case (state_q)
            TAP_TEST_LOGIC_RESET: state_d = jtag.tms ? TAP_TEST_LOGIC_RESET : TAP_RUN_TEST_IDLE;
            TAP_RUN_TEST_IDLE:    state_d = jtag.tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
            TAP_SELECT_DR_SCAN:   state_d = jtag.tms ? TAP_SELECT_IR_SCAN : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR:       state_d = jtag.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR:         state_d = jtag.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR:         state_d = jtag.tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:         state_d = jtag.tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR:         state_d = jtag.tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:        state_d = jtag.tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
            TAP_SELECT_IR_SCAN:   state_d = jtag.tms ? TAP_TEST_LOGIC_RESET : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR:       state_d = jtag.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR:         state_d = jtag.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR:         state_d = jtag.tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:         state_d = jtag.tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR:         state_d = jtag.tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:        state_d = jtag.tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
            default:              state_d = TAP_TEST_LOGIC_RESET;
        endcase
    end

    always_ff @(posedge jtag.tck or negedge jtag.trst_n) begin
        if (!jtag.trst_n) begin
            state_q <= TAP_TEST_LOGIC_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // instruction register, also forced to IDCODE while in Test-Logic-Reset
    always_ff @(posedge jtag.tck or negedge jtag.trst_n) begin
        if (!jtag.trst_n) begin
            ir_q <= INSTR_IDCODE;
        end else if (state_q == TAP_TEST_LOGIC_RESET) begin
            ir_q <= INSTR_IDCODE;
        end else if (state_q == TAP_UPDATE_IR) begin
            ir_q <= ir_shift_q;
        end
    end

    always_ff @(posedge jtag.tck) begin
        if (state_q == TAP_CAPTURE_IR) begin
            ir_shift_q <= IR_CAPTURE;
        end else if (state_q == TAP_SHIFT_IR) begin
            ir_shift_q <= {jtag.tdi, ir_shift_q[`CHIP_IR_LEN-1:1]};
        end
    end

    // every code other than IDCODE selects the bypass bit
    assign idcode_sel = (ir_q == INSTR_IDCODE);

    always_ff @(posedge jtag.tck) begin
        if (state_q == TAP_CAPTURE_DR) begin
            if (idcode_sel) begin
                idcode_q <= IDCODE_VALUE;
            end else begin
                bypass_q <= 1'b0;
            end
        end else if (state_q == TAP_SHIFT_DR) begin
            if (idcode_sel) begin
                idcode_q <= {jtag.tdi, idcode_q[31:1]};
            end else begin
                bypass_q <= jtag.tdi;
            end
        end
    end

    // tdo launched on the falling edge, half a tck before the board samples it
    always_ff @(negedge jtag.tck or negedge jtag.trst_n) begin
        if (!jtag.trst_n) begin
            tdo_q <= 1'b0;
        end else if (state_q == TAP_SHIFT_IR) begin
            tdo_q <= ir_shift_q[0];
        end else if (state_q == TAP_SHIFT_DR) begin
            tdo_q <= idcode_sel ? idcode_q[0] : bypass_q;
        end else begin
            tdo_q <= 1'b0;
        end
    end

    assign jtag.tdo = tdo_q;

endmodule

/* rst_sync.sv */
// reset synchronizer for the ref_clk domain, async assert and sync release
`timescale 1ns/1ns
`include "chip_io_defines.svh"

module rst_sync (
    input  logic ref_clk_i,
    input  logic rst_n_i,
    output logic rst_n_o
);

    localparam int STAGES = `CHIP_RST_SYNC_STAGES;

    logic [STAGES-1:0] sync_q;

    // ones ripple in after release, last stage drives the core reset
    always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[STAGES-2:0], 1'b1};
        end
    end

    assign rst_n_o = sync_q[STAGES-1];

endmodule

/* chip_io_top.sv */
// chip IO top with pad ring, two JTAG TAPs, reset synchronizer and UART loopback
`timescale 1ns/1ns
`include "chip_io_defines.svh"

module chip_io_top (
    inout  wire  pad_uart_rx_io,
    inout  wire  pad_uart_tx_io,
    inout  wire  pad_reset_n_io,
    inout  wire  pad_xtal_in_io,
    inout  wire  pad_bypass_io,
    inout  wire  pad_jtag_tck_io,
    inout  wire  pad_jtag_tms_io,
    inout  wire  pad_jtag_tdi_io,
    inout  wire  pad_jtag_tdo_io,
    inout  wire  pad_jtag_trst_io,
    inout  wire  pad_jtag_ot_tck_io,
    inout  wire  pad_jtag_ot_tms_io,
    inout  wire  pad_jtag_ot_tdi_io,
    inout  wire  pad_jtag_ot_tdo_io,
    inout  wire  pad_jtag_ot_trst_io,
    output logic ref_clk_o,
    output logic rstn_o,
    output logic bypass_o
);

    // rx level goes straight back out on tx, standing in for the core UART
    logic uart_loop;
    // unsynchronized reset from the pad
    logic pad_rst_n;

    jtag_if jtag_main ();
    jtag_if jtag_ot ();

    pad_frame u_pad_frame (
        .uart_tx_i           (uart_loop),
        .uart_rx_o           (uart_loop),
        .ref_clk_o           (ref_clk_o),
        .rstn_o              (pad_rst_n),
        .bypass_o            (bypass_o),
        .jtag_main           (jtag_main),
        .jtag_ot             (jtag_ot),
        .pad_uart_rx_io      (pad_uart_rx_io),
        .pad_uart_tx_io      (pad_uart_tx_io),
        .pad_reset_n_io      (pad_reset_n_io),
        .pad_xtal_in_io      (pad_xtal_in_io),
        .pad_bypass_io       (pad_bypass_io),
        .pad_jtag_tck_io     (pad_jtag_tck_io),
        .pad_jtag_tms_io     (pad_jtag_tms_io),
        .pad_jtag_tdi_io     (pad_jtag_tdi_io),
        .pad_jtag_tdo_io     (pad_jtag_tdo_io),
        .pad_jtag_trst_io    (pad_jtag_trst_io),
        .pad_jtag_ot_tck_io  (pad_jtag_ot_tck_io),
        .pad_jtag_ot_tms_io  (pad_jtag_ot_tms_io),
        .pad_jtag_ot_tdi_io  (pad_jtag_ot_tdi_io),
        .pad_jtag_ot_tdo_io  (pad_jtag_ot_tdo_io),
        .pad_jtag_ot_trst_io (pad_jtag_ot_trst_io)
    );

    jtag_tap #(.IDCODE_VALUE(`CHIP_IDCODE_MAIN)) u_tap_main (.jtag(jtag_main));
    jtag_tap #(.IDCODE_VALUE(`CHIP_IDCODE_OT))   u_tap_ot   (.jtag(jtag_ot));

    rst_sync u_rst_sync (
        .ref_clk_i (ref_clk_o),
        .rst_n_i   (pad_rst_n),
        .rst_n_o   (rstn_o)
    );

endmodule

/* tb_checker.sv */
// checker for tdo shift words, reset release timing and pad pass-through levels
`timescale 1ns/1ns

module tb_checker (
    input  logic        ref_clk_i,
    input  logic        ref_clk_out_i,
    input  logic        bypass_pin_i,
    input  logic        bypass_out_i,
    input  logic        pad_rst_n_i,
    input  logic        rstn_i,
    input  logic        tck_main_i,
    input  logic        tdo_main_i,
    input  logic        cap_main_i,
    input  logic        cmp_main_i,
    input  logic [31:0] exp_main_i,
    input  logic        tck_ot_i,
    input  logic        tdo_ot_i,
    input  logic        cap_ot_i,
    input  logic        cmp_ot_i,
    input  logic [31:0] exp_ot_i,
    input  int          nbits_i,
    input  logic        uart_chk_i,
    input  logic        rx_en_i,
    input  logic        rx_val_i,
    input  logic        uart_tx_i,
    input  logic        report_i,
    output int          err_count_o,
    output int          chk_count_o
);

    logic [31:0] word_main = '0;
    logic [31:0] word_ot = '0;
    int edges = 0;
    int clk_in_edges = 0;
    int clk_out_edges = 0;
    int word_err = 0;
    int word_chk = 0;
    int level_err = 0;
    int level_chk = 0;
    logic exp_tx;

    function automatic logic [31:0] low_bits(input logic [31:0] v, input int n);
        logic [63:0] mask;
        mask = (64'd1 << n) - 64'd1;
        return v & mask[31:0];
    endfunction

    // tdo arrives LSB first, newest bit enters at the top
    always @(posedge tck_main_i) begin
        if (cap_main_i) word_main <= {tdo_main_i, word_main[31:1]};
    end

    always @(posedge tck_ot_i) begin
        if (cap_ot_i) word_ot <= {tdo_ot_i, word_ot[31:1]};
    end

    always @(posedge ref_clk_i) begin
        if (cmp_main_i) begin
            word_chk++;
            if ((word_main >> (32 - nbits_i)) !== low_bits(exp_main_i, nbits_i)) begin
                word_err++;
                $display("ERROR %0t main tdo word %h expected %h over %0d bits", $time,
                         word_main >> (32 - nbits_i), low_bits(exp_main_i, nbits_i), nbits_i);
            end
        end
        if (cmp_ot_i) begin
            word_chk++;
            if ((word_ot >> (32 - nbits_i)) !== low_bits(exp_ot_i, nbits_i)) begin
                word_err++;
                $display("ERROR %0t ot tdo word %h expected %h over %0d bits", $time,
                         word_ot >> (32 - nbits_i), low_bits(exp_ot_i, nbits_i), nbits_i);
            end
        end
    end

    // rising ref_clk edges since the reset pad went high, saturating
    always @(posedge ref_clk_i) begin
        if (!pad_rst_n_i) edges <= 0;
        else if (edges < 3) edges <= edges + 1;
    end

    // rising edges on both sides of the clock pad
    always @(posedge ref_clk_i) begin
        clk_in_edges <= clk_in_edges + 1;
    end

    always @(posedge ref_clk_out_i) begin
        clk_out_edges <= clk_out_edges + 1;
    end

    always @(negedge ref_clk_i) begin
        // nothing has settled before the first rising edge
        if (clk_in_edges > 0) begin
            if (rstn_i !== (pad_rst_n_i && edges >= 2)) begin
                level_err++;
                $display("ERROR %0t rstn_o is %b with reset pad %b after %0d edges", $time,
                         rstn_i, pad_rst_n_i, edges);
            end
            if (pad_rst_n_i && edges == 2) level_chk++;
            // clock and bypass pads pass straight through to the core side
            level_chk++;
            if (clk_out_edges != clk_in_edges) begin
                level_err++;
                $display("ERROR %0t ref_clk_o saw %0d rising edges, crystal pad %0d", $time,
                         clk_out_edges, clk_in_edges);
            end
            if (bypass_out_i !== bypass_pin_i) begin
                level_err++;
                $display("ERROR %0t bypass_o is %b with bypass pad %b", $time,
                         bypass_out_i, bypass_pin_i);
            end
            if (uart_chk_i) begin
                // a released rx pad reads high through its pull-up
                exp_tx = rx_en_i ? rx_val_i : 1'b1;
                level_chk++;
                if (uart_tx_i !== exp_tx) begin
                    level_err++;
                    $display("ERROR %0t uart tx pad %b expected %b", $time, uart_tx_i, exp_tx);
                end
            end
        end
    end

    assign err_count_o = word_err + level_err;
    assign chk_count_o = word_chk + level_chk;

    always @(posedge report_i) begin
        $display("checks %0d errors %0d", chk_count_o, err_count_o);
    end

endmodule

/* tb_chip_io.sv */
// testbench top with clock, reset, case file reader and bit-banged JTAG driver
`timescale 1ns/1ns
`include "chip_io_defines.svh"

module tb_chip_io
    import chip_io_pkg::*;
();

    localparam int MAX_CASES = 32;
    localparam int DRIVE_DELAY = 1;
    // Capture-IR pattern required by IEEE 1149.1, two LSBs 01
    localparam logic [31:0] IR_CAPTURE_EXP = 32'h1;

    logic ref_clk;
    logic reset_n;
    logic bypass_pin;
    logic rx_en;
    logic rx_val;
    logic tck_m, tms_m, tdi_m, trst_m;
    logic tck_o, tms_o, tdi_o, trst_o;
    logic sel_main, sel_ot;
    logic cap_main, cap_ot;
    logic cmp_main, cmp_ot;
    logic [31:0] exp_main, exp_ot;
    int nbits_cmp;
    logic uart_chk;
    logic report;
    int err_count, chk_count;
    int bad_cases;
    int cycles = 0;
    int cycle_limit;
    int num_cases;

    // five hex words per case: sel, op, data, bits, expected
    logic [31:0] case_mem [0:5*MAX_CASES-1];
    logic [15:0] case_pat [0:MAX_CASES-1];

    wire pad_uart_rx, pad_uart_tx, pad_reset_n, pad_xtal_in, pad_bypass;
    wire pad_jtag_tck, pad_jtag_tms, pad_jtag_tdi, pad_jtag_tdo, pad_jtag_trst;
    wire pad_jtag_ot_tck, pad_jtag_ot_tms, pad_jtag_ot_tdi, pad_jtag_ot_tdo, pad_jtag_ot_trst;
    wire ref_clk_out, rstn_out, bypass_out;

    assign pad_xtal_in = ref_clk;
    assign pad_reset_n = reset_n;
    assign pad_bypass = bypass_pin;
    // released rx pad falls back to the pad pull-up
    assign pad_uart_rx = rx_en ? rx_val : 1'bz;
    assign pad_jtag_tck = tck_m;
    assign pad_jtag_tms = tms_m;
    assign pad_jtag_tdi = tdi_m;
    assign pad_jtag_trst = trst_m;
    assign pad_jtag_ot_tck = tck_o;
    assign pad_jtag_ot_tms = tms_o;
    assign pad_jtag_ot_tdi = tdi_o;
    assign pad_jtag_ot_trst = trst_o;

    chip_io_top uut (
        .pad_uart_rx_io      (pad_uart_rx),
        .pad_uart_tx_io      (pad_uart_tx),
        .pad_reset_n_io      (pad_reset_n),
        .pad_xtal_in_io      (pad_xtal_in),
        .pad_bypass_io       (pad_bypass),
        .pad_jtag_tck_io     (pad_jtag_tck),
        .pad_jtag_tms_io     (pad_jtag_tms),
        .pad_jtag_tdi_io     (pad_jtag_tdi),
        .pad_jtag_tdo_io     (pad_jtag_tdo),
        .pad_jtag_trst_io    (pad_jtag_trst),
        .pad_jtag_ot_tck_io  (pad_jtag_ot_tck),
        .pad_jtag_ot_tms_io  (pad_jtag_ot_tms),
        .pad_jtag_ot_tdi_io  (pad_jtag_ot_tdi),
        .pad_jtag_ot_tdo_io  (pad_jtag_ot_tdo),
        .pad_jtag_ot_trst_io (pad_jtag_ot_trst),
        .ref_clk_o           (ref_clk_out),
        .rstn_o              (rstn_out),
        .bypass_o            (bypass_out)
    );

    tb_checker u_checker (
        .ref_clk_i     (pad_xtal_in),
        .ref_clk_out_i (ref_clk_out),
        .bypass_pin_i  (pad_bypass),
        .bypass_out_i  (bypass_out),
        .pad_rst_n_i   (pad_reset_n),
        .rstn_i        (rstn_out),
        .tck_main_i    (pad_jtag_tck),
        .tdo_main_i    (pad_jtag_tdo),
        .cap_main_i    (cap_main),
        .cmp_main_i    (cmp_main),
        .exp_main_i    (exp_main),
        .tck_ot_i      (pad_jtag_ot_tck),
        .tdo_ot_i      (pad_jtag_ot_tdo),
        .cap_ot_i      (cap_ot),
        .cmp_ot_i      (cmp_ot),
        .exp_ot_i      (exp_ot),
        .nbits_i       (nbits_cmp),
        .uart_chk_i    (uart_chk),
        .rx_en_i       (rx_en),
        .rx_val_i      (rx_val),
        .uart_tx_i     (pad_uart_tx),
        .report_i      (report),
        .err_count_o   (err_count),
        .chk_count_o   (chk_count)
    );

    always #2 ref_clk = ~ref_clk;

    always @(posedge ref_clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d reference cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic wait_ref(input int n);
        repeat (n) @(posedge ref_clk);
        #DRIVE_DELAY;
        // bypass pin changes at every drive point so its pad sees both levels
        bypass_pin = ~bypass_pin;
    endtask

    task automatic read_cases();
        int total_bits;
        total_bits = 0;
        for (int i = 0; i < 5 * MAX_CASES; i++) begin
            case_mem[i] = 32'hffff_ffff;
        end
        $readmemh("jtag_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_mem[5*num_cases+1] != 32'hffff_ffff) begin
            total_bits += int'(case_mem[5*num_cases+3]);
            num_cases++;
        end
        if (num_cases == 0) begin
            $display("no test cases could be read from jtag_cases.txt");
            bad_cases++;
        end
        cycle_limit = 200 + 40 * total_bits;
    endtask

    // 0 main only, 1 ot only, 2 both
    task automatic select_taps(input logic [31:0] code);
        sel_main = (code != 32'd1);
        sel_ot = (code != 32'd0);
    endtask

    // one tck period, tms and tdi set while tck is low
    task automatic clock_tap(input logic tms_v, input logic tdi_v, input logic cap_v);
        if (sel_main) begin
            tms_m = tms_v;
            tdi_m = tdi_v;
        end
        if (sel_ot) begin
            tms_o = tms_v;
            tdi_o = tdi_v;
        end
        cap_main = sel_main & cap_v;
        cap_ot = sel_ot & cap_v;
        wait_ref(2);
        if (sel_main) tck_m = 1'b1;
        if (sel_ot) tck_o = 1'b1;
        wait_ref(2);
        tck_m = 1'b0;
        tck_o = 1'b0;
    endtask

    task automatic pulse_trst();
        if (sel_main) trst_m = 1'b0;
        if (sel_ot) trst_o = 1'b0;
        wait_ref(2);
        trst_m = 1'b1;
        trst_o = 1'b1;
        wait_ref(2);
        clock_tap(1'b0, 1'b0, 1'b0);
    endtask

    // full scan from Run-Test-Idle back to Run-Test-Idle
    task automatic shift_reg(input logic is_ir, input logic [31:0] tdi_word, input int n);
        clock_tap(1'b1, 1'b0, 1'b0);
        if (is_ir) clock_tap(1'b1, 1'b0, 1'b0);
        clock_tap(1'b0, 1'b0, 1'b0);
        clock_tap(1'b0, 1'b0, 1'b0);
        for (int i = 0; i < n; i++) begin
            clock_tap(i == n - 1, tdi_word[i], 1'b1);
        end
        clock_tap(1'b1, 1'b0, 1'b0);
        clock_tap(1'b0, 1'b0, 1'b0);
    endtask

    task automatic request_compare(input logic [31:0] em, input logic [31:0] eo, input int n);
        exp_main = em;
        exp_ot = eo;
        nbits_cmp = n;
        cmp_main = sel_main;
        cmp_ot = sel_ot;
        wait_ref(1);
        cmp_main = 1'b0;
        cmp_ot = 1'b0;
    endtask

    task automatic run_case(input int idx);
        logic [31:0] sel, op, data, expv, word;
        int n;
        sel = case_mem[5*idx];
        op = case_mem[5*idx+1];
        data = case_mem[5*idx+2];
        n = int'(case_mem[5*idx+3]);
        expv = case_mem[5*idx+4];
        word = (data != 32'd0) ? data : {16'h0, case_pat[idx]};
        case (op)
            32'd1: begin
                select_taps(sel);
                pulse_trst();
                shift_reg(1'b0, data, n);
                request_compare(expv, expv, n);
            end
            32'd2: begin
                select_taps(sel);
                pulse_trst();
                // in the two-TAP case only main leaves IDCODE
                if (sel == 32'd2) select_taps(32'd0);
                shift_reg(1'b1, 32'(INSTR_BYPASS), `CHIP_IR_LEN);
                request_compare(IR_CAPTURE_EXP, IR_CAPTURE_EXP, `CHIP_IR_LEN);
                select_taps(sel);
                shift_reg(1'b0, word, n);
                // bypass returns a captured 0 followed by tdi one tck late
                request_compare(word << 1, (sel == 32'd2) ? expv : word << 1, n);
            end
            32'd3: begin
                reset_n = 1'b0;
                wait_ref(n);
                reset_n = 1'b1;
                wait_ref(4);
            end
            32'd4: begin
                uart_chk = 1'b1;
                for (int i = 0; i < n; i++) begin
                    rx_en = 1'b1;
                    rx_val = data[i];
                    wait_ref(2);
                end
                // end low so the release shows the pull-up lifting the pad
                rx_val = 1'b0;
                wait_ref(2);
                rx_en = 1'b0;
                wait_ref(4);
                uart_chk = 1'b0;
            end
            default: begin
                $display("case %0d has an unknown operation code %0h", idx, op);
                bad_cases++;
            end
        endcase
    endtask

    initial begin
        ref_clk = 1'b0;
        reset_n = 1'b0;
        bypass_pin = 1'b0;
        rx_en = 1'b0;
        rx_val = 1'b0;
        {tck_m, tms_m, tdi_m, trst_m} = 4'b0100;
        {tck_o, tms_o, tdi_o, trst_o} = 4'b0100;
        {sel_main, sel_ot, cap_main, cap_ot, cmp_main, cmp_ot} = 6'b0;
        exp_main = 32'd0;
        exp_ot = 32'd0;
        nbits_cmp = 32;
        uart_chk = 1'b0;
        report = 1'b0;
        bad_cases = 0;
        cycle_limit = 0;
        void'($urandom(88));
        read_cases();
        for (int i = 0; i < MAX_CASES; i++) begin
            case_pat[i] = 16'($urandom());
        end
        wait_ref(16);
        reset_n = 1'b1;
        trst_m = 1'b1;
        trst_o = 1'b1;
        wait_ref(4);
        for (int i = 0; i < num_cases; i++) begin
            run_case(i);
        end
        wait_ref(4);
        report = 1'b1;
        #1;
        if (err_count == 0 && bad_cases == 0 && chk_count > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* jtag_cases.txt */
// sel op data bits expected, hex; sel 0 main, 1 ot, 2 main in bypass with ot in idcode
// op 1 idcode, 2 bypass (data 0 takes a random word), 3 reset pulse, 4 uart rx levels
0 1 00000000 20 1a5a0db3
1 1 00000000 20 2c3e5a71
0 2 00000000 11 00000000
1 2 00000000 11 00000000
0 2 0000c35a 11 00000000
2 2 00000000 20 2c3e5a71
0 4 000000b6 08 00000000
0 3 00000000 08 00000000
1 1 ffffffff 20 2c3e5a71
0 1 00000000 20 1a5a0db3

/* filelist.f */
+incdir+.
chip_io_pkg.sv
jtag_if.sv
pad_cell.sv
pad_frame.sv
jtag_tap.sv
rst_sync.sv
chip_io_top.sv
tb_checker.sv
tb_chip_io.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the chip IO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_chip_io -o tb_chip_io > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/tb_chip_io > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
exit 0
